/* sd_pkg.sv */
`default_nettype none

package sd_pkg;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  typedef logic [7:0] byte_t;

  // one SD command as it goes out on MOSI, less the start and end bits
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
    byte_t       crc;
  } cmd_frame_t;

  // host read request, byte or block address depending on the card
  typedef struct packed {
    logic [31:0] addr;
  } rd_req_t;

  // ----------------------------------------------------------------------
  // protocol constants
  // ----------------------------------------------------------------------

  localparam int BLOCK_BYTES = 512;

  // command indices
  localparam logic [5:0] CMD_GO_IDLE       = 6'd0;
  localparam logic [5:0] CMD_SEND_IF_COND  = 6'd8;
  localparam logic [5:0] CMD_READ_SINGLE   = 6'd17;
  localparam logic [5:0] CMD_APP           = 6'd55;
  localparam logic [5:0] ACMD_SEND_OP_COND = 6'd41;

  // arguments
  localparam logic [31:0] ARG_IF_COND = 32'h0000_01AA;
  localparam logic [31:0] ARG_HCS     = 32'h4000_0000;

  // crc bytes, only CMD0 and CMD8 are checked by the card in SPI mode
  localparam byte_t CRC_CMD0 = 8'h95;
  localparam byte_t CRC_CMD8 = 8'h87;
  localparam byte_t CRC_NONE = 8'hFF;

  // R1 responses
  localparam byte_t R1_IDLE  = 8'h01;
  localparam byte_t R1_READY = 8'h00;

  localparam byte_t DATA_TOKEN = 8'hFE;
  localparam byte_t FILL_BYTE  = 8'hFF;

  // 10 bytes with cs high give 80 clocks, above the 74 the card asks for
  localparam int INIT_BYTES = 10;
  localparam int POLL_LIMIT = 16;

endpackage

`default_nettype wire

/* spi_byte_engine.sv */
`default_nettype none

module spi_byte_engine import sd_pkg::*; #(
  parameter int divider = 5
) (
  input  wire logic  CLK,
  input  wire logic  RST,
  input  wire logic  xfer_stb,
  input  wire byte_t xfer_data,
  output logic       xfer_ready,
  output logic       rx_stb,
  output byte_t      rx_data,
  output logic       mosi,
  input  wire logic  miso,
  output logic       sclk
);

  localparam int CNT_W = (divider > 1) ? $clog2(divider) : 1;

  logic [CNT_W-1:0] tick_cnt;
  logic             tick;
  logic             busy;
  logic [2:0]       bit_cnt;
  byte_t            tx_sh;
  byte_t            rx_sh;

  // ----------------------------------------------------------------------
  // half-bit tick
  // ----------------------------------------------------------------------

  // free running, so a new byte waits up to one divider period for phase
  assign tick = (tick_cnt == CNT_W'(divider - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // mode 0 shifter
  // ----------------------------------------------------------------------

  assign xfer_ready = ~busy;
  // idle line stays high, which is also the fill byte
  assign mosi       = busy ? tx_sh[7] : 1'b1;
  assign rx_data    = rx_sh;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      sclk    <= 1'b0;
      bit_cnt <= '0;
      rx_stb  <= 1'b0;
    end else begin
      rx_stb <= 1'b0;
      if (!busy) begin
        if (xfer_stb) begin
          busy    <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (tick) begin
        if (!sclk) begin
          sclk <= 1'b1;
        end else begin
          // falling edge closes one bit
          sclk    <= 1'b0;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            busy   <= 1'b0;
            rx_stb <= 1'b1;
          end
        end
      end
    end
  end

  // sample on rising sclk, shift the next bit out on falling sclk
  always_ff @(posedge CLK) begin
    if (!busy && xfer_stb) begin
      tx_sh <= xfer_data;
    end else if (busy && tick && sclk) begin
      tx_sh <= {tx_sh[6:0], 1'b1};
    end
    if (busy && tick && !sclk) begin
      rx_sh <= {rx_sh[6:0], miso};
    end
  end

endmodule

`default_nettype wire

/* sd_sequencer.sv */
`default_nettype none

module sd_sequencer import sd_pkg::*; #(
  parameter int retry_limit = 4
) (
  input  wire logic    CLK,
  input  wire logic    RST,
  input  wire logic    rd_stb,
  input  wire rd_req_t rd_req,
  output logic         ready,
  output logic         rd_ack,
  output logic         init_err,
  output logic         cs,
  output logic         xfer_stb,
  output byte_t        xfer_data,
  input  wire logic    xfer_ready,
  input  wire logic    rx_stb,
  input  wire byte_t   rx_data,
  output logic         push,
  output byte_t        push_data,
  input  wire logic    full
);

  localparam int RETRY_W = (retry_limit > 1) ? $clog2(retry_limit) : 1;

  typedef enum logic [3:0] {
    ST_PREAMBLE,
    ST_FRAME,
    ST_POLL,
    ST_R7,
    ST_TOKEN,
    ST_DATA,
    ST_CRC,
    ST_IDLE,
    ST_HALT
  } state_t;

  state_t             state;
  cmd_frame_t         frame;
  logic [9:0]         byte_cnt;
  logic [4:0]         poll_cnt;
  logic [RETRY_W-1:0] attempt_cnt;
  logic               pend;
  byte_t              r7_prev;
  byte_t              tx_byte;
  logic               can_issue;

  // 0x40|index, argument MSB first, crc
  function automatic byte_t frame_byte(cmd_frame_t f, logic [2:0] idx);
    case (idx)
      3'd0:    frame_byte = {2'b01, f.index};
      3'd1:    frame_byte = f.arg[31:24];
      3'd2:    frame_byte = f.arg[23:16];
      3'd3:    frame_byte = f.arg[15:8];
      3'd4:    frame_byte = f.arg[7:0];
      default: frame_byte = f.crc;
    endcase
  endfunction

  assign tx_byte = (state == ST_FRAME) ? frame_byte(frame, byte_cnt[2:0]) : FILL_BYTE;

  // one byte in flight at a time; the gap after a push lets full settle
  // before the next block byte is clocked
  assign can_issue = !pend && xfer_ready && !push &&
                     (state != ST_IDLE) && (state != ST_HALT) &&
                     !((state == ST_DATA) && full);

  always_ff @(posedge CLK or posedge RST) begin : fsm
    logic       fail;
    logic       start;
    cmd_frame_t cmd;
    if (RST) begin
      state       <= ST_PREAMBLE;
      frame       <= '0;
      byte_cnt    <= '0;
      poll_cnt    <= '0;
      attempt_cnt <= '0;
      pend        <= 1'b0;
      r7_prev     <= '0;
      cs          <= 1'b1;
      ready       <= 1'b0;
      rd_ack      <= 1'b0;
      init_err    <= 1'b0;
      xfer_stb    <= 1'b0;
      xfer_data   <= FILL_BYTE;
      push        <= 1'b0;
      push_data   <= '0;
    end else begin
      fail  = 1'b0;
      start = 1'b0;
      cmd   = frame;

      xfer_stb <= can_issue;
      push     <= 1'b0;
      rd_ack   <= 1'b0;
      if (can_issue) begin
        pend      <= 1'b1;
        xfer_data <= tx_byte;
      end else if (rx_stb) begin
        pend <= 1'b0;
      end

      case (state)
        ST_PREAMBLE: begin
          if (rx_stb) begin
            if (byte_cnt == 10'(INIT_BYTES - 1)) begin
              start = 1'b1;
              cmd   = '{index: CMD_GO_IDLE, arg: 32'h0, crc: CRC_CMD0};
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end

        ST_FRAME: begin
          if (rx_stb) begin
            if (byte_cnt == 10'd5) begin
              poll_cnt <= '0;
              state    <= ST_POLL;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end

        // ----------------------------------------------------------------
        // response handling per command
        // ----------------------------------------------------------------
        ST_POLL: begin
          if (rx_stb) begin
            if (rx_data[7]) begin
              if (poll_cnt == 5'(POLL_LIMIT - 1)) begin
                fail = 1'b1;
              end else begin
                poll_cnt <= poll_cnt + 1'b1;
              end
            end else begin
              case (frame.index)
                CMD_GO_IDLE: begin
                  if (rx_data == R1_IDLE) begin
                    start = 1'b1;
                    cmd   = '{index: CMD_SEND_IF_COND, arg: ARG_IF_COND, crc: CRC_CMD8};
                  end else begin
                    fail = 1'b1;
                  end
                end
                CMD_SEND_IF_COND: begin
                  if (rx_data == R1_IDLE) begin
                    byte_cnt <= '0;
                    state    <= ST_R7;
                  end else begin
                    fail = 1'b1;
                  end
                end
                CMD_APP: begin
                  if (rx_data[7:1] == 7'd0) begin
                    start = 1'b1;
                    cmd   = '{index: ACMD_SEND_OP_COND, arg: ARG_HCS, crc: CRC_NONE};
                  end else begin
                    fail = 1'b1;
                  end
                end
                ACMD_SEND_OP_COND: begin
                  if (rx_data == R1_READY) begin
                    cs          <= 1'b1;
                    ready       <= 1'b1;
                    attempt_cnt <= '0;
                    state       <= ST_IDLE;
                  end else if (rx_data == R1_IDLE) begin
                    // card still busy so CMD55/ACMD41 goes round again
                    start = 1'b1;
                    cmd   = '{index: CMD_APP, arg: 32'h0, crc: CRC_NONE};
                  end else begin
                    fail = 1'b1;
                  end
                end
                default: begin
                  if (rx_data == R1_READY) begin
                    state <= ST_TOKEN;
                  end else begin
                    fail = 1'b1;
                  end
                end
              endcase
            end
          end
        end

        // trailing four R7 bytes with the voltage byte and echo pattern checked
        ST_R7: begin
          if (rx_stb) begin
            r7_prev <= rx_data;
            if (byte_cnt == 10'd3) begin
              if ({r7_prev, rx_data} == ARG_IF_COND[15:0]) begin
                start = 1'b1;
                cmd   = '{index: CMD_APP, arg: 32'h0, crc: CRC_NONE};
              end else begin
                fail = 1'b1;
              end
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end

        // ----------------------------------------------------------------
        // block read
        // ----------------------------------------------------------------
        ST_TOKEN: begin
          if (rx_stb) begin
            if (rx_data == DATA_TOKEN) begin
              byte_cnt <= '0;
              state    <= ST_DATA;
            end else if (rx_data != FILL_BYTE) begin
              // error token
              fail = 1'b1;
            end
          end
        end

        ST_DATA: begin
          if (rx_stb) begin
            push      <= 1'b1;
            push_data <= rx_data;
            if (byte_cnt == 10'(BLOCK_BYTES - 1)) begin
              byte_cnt <= '0;
              state    <= ST_CRC;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end

        // data crc is clocked through and dropped
        ST_CRC: begin
          if (rx_stb) begin
            if (byte_cnt == 10'd1) begin
              cs     <= 1'b1;
              rd_ack <= 1'b1;
              ready  <= 1'b1;
              state  <= ST_IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end

        ST_IDLE: begin
          if (rd_stb) begin
            ready <= 1'b0;
            start = 1'b1;
            cmd   = '{index: CMD_READ_SINGLE, arg: rd_req.addr, crc: CRC_NONE};
          end
        end

        default: begin
          // halted until reset
        end
      endcase

      if (fail) begin
        cs       <= 1'b1;
        byte_cnt <= '0;
        if (attempt_cnt == RETRY_W'(retry_limit - 1)) begin
          init_err <= 1'b1;
          state    <= ST_HALT;
        end else begin
          attempt_cnt <= attempt_cnt + 1'b1;
          state       <= ST_PREAMBLE;
        end
      end else if (start) begin
        frame    <= cmd;
        byte_cnt <= '0;
        cs       <= 1'b0;
        state    <= ST_FRAME;
      end
    end
  end

endmodule

`default_nettype wire

/* byte_fifo.sv */
`default_nettype none

module byte_fifo import sd_pkg::*; #(
  parameter int fifo_depth = 16
) (
  input  wire logic  CLK,
  input  wire logic  RST,
  input  wire logic  push,
  input  wire byte_t push_data,
  output logic       full,
  output logic       out_stb,
  output byte_t      out_data,
  input  wire logic  out_busy
);

  localparam int AW = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int CW = $clog2(fifo_depth + 1);

  byte_t         mem [fifo_depth];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign full    = (count == CW'(fifo_depth));
  assign do_push = push && !full;
  // sink busy holds everything in place
  assign do_pop  = (count != '0) && !out_busy;

  // ----------------------------------------------------------------------
  // pointers and fill level
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      out_stb <= 1'b0;
    end else begin
      out_stb <= do_pop;
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // storage and registered output
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      out_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* sd_reader.sv */
`default_nettype none

module sd_reader import sd_pkg::*; #(
  parameter int divider     = 5,
  parameter int fifo_depth  = 16,
  parameter int retry_limit = 4
) (
  input  wire logic    CLK,
  input  wire logic    RST,

  // host side
  input  wire logic    rd_stb,
  input  wire rd_req_t rd_req,
  output logic         ready,
  output logic         rd_ack,
  output logic         init_err,

  // byte stream to the sink
  output logic         out_stb,
  output byte_t        out_data,
  input  wire logic    out_busy,

  // card
  output logic         mosi,
  input  wire logic    miso,
  output logic         sclk,
  output logic         cs
);

  // sequencer to spi engine
  logic  xfer_stb;
  byte_t xfer_data;
  logic  xfer_ready;
  logic  rx_stb;
  byte_t rx_data;

  // sequencer to fifo
  logic  push;
  byte_t push_data;
  logic  full;

  spi_byte_engine #(
    .divider    (divider)
  ) u_spi (
    .CLK        (CLK),
    .RST        (RST),
    .xfer_stb   (xfer_stb),
    .xfer_data  (xfer_data),
    .xfer_ready (xfer_ready),
    .rx_stb     (rx_stb),
    .rx_data    (rx_data),
    .mosi       (mosi),
    .miso       (miso),
    .sclk       (sclk)
  );

  sd_sequencer #(
    .retry_limit (retry_limit)
  ) u_seq (
    .CLK         (CLK),
    .RST         (RST),
    .rd_stb      (rd_stb),
    .rd_req      (rd_req),
    .ready       (ready),
    .rd_ack      (rd_ack),
    .init_err    (init_err),
    .cs          (cs),
    .xfer_stb    (xfer_stb),
    .xfer_data   (xfer_data),
    .xfer_ready  (xfer_ready),
    .rx_stb      (rx_stb),
    .rx_data     (rx_data),
    .push        (push),
    .push_data   (push_data),
    .full        (full)
  );

  byte_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .CLK        (CLK),
    .RST        (RST),
    .push       (push),
    .push_data  (push_data),
    .full       (full),
    .out_stb    (out_stb),
    .out_data   (out_data),
    .out_busy   (out_busy)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int period     = 10,
  parameter int rst_cycles = 5
) (
  output logic CLK,
  output logic RST
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #(period / 2) CLK = ~CLK;
  end

  initial begin
    RST = 1'b1;
    repeat (rst_cycles) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

/* sd_card_model.sv */
`default_nettype none

module sd_card_model import sd_pkg::*; (
  input  wire logic CLK,
  input  wire logic RST,
  input  wire logic cs,
  input  wire logic sclk,
  input  wire logic mosi,
  output logic      miso,
  input  var int    resp_delay,
  input  var int    busy_replies,
  input  wire logic mute
);

  timeunit 1ns;
  timeprecision 100ps;

  cmd_frame_t frame_log[$];
  int         pre_cnt;
  int         pre_first;
  byte_t      resp_q[$];
  byte_t      fbuf[6];
  int         fidx;
  byte_t      in_sh;
  int         in_bits;
  byte_t      out_sh;
  int         out_bits;
  int         busy_left;
  logic       sclk_q;

  function automatic byte_t block_byte(logic [31:0] a, int i);
    block_byte = (a[31:24] + a[23:16] + a[15:8] + a[7:0]) ^ 8'(i) ^ {7'd0, i[8]};
  endfunction

  function automatic byte_t next_byte();
    if (cs) begin
      resp_q.delete();
      next_byte = FILL_BYTE;
    end else if (resp_q.size() > 0) begin
      next_byte = resp_q.pop_front();
    end else begin
      next_byte = FILL_BYTE;
    end
  endfunction

  // ----------------------------------------------------------------------
  // command decode and answers
  // ----------------------------------------------------------------------

  task automatic respond(cmd_frame_t f);
    if (mute && f.index == CMD_GO_IDLE) begin
      return;
    end
    repeat (resp_delay) resp_q.push_back(FILL_BYTE);
    case (f.index)
      CMD_GO_IDLE:      resp_q.push_back(R1_IDLE);
      CMD_SEND_IF_COND: begin
        resp_q.push_back(R1_IDLE);
        resp_q.push_back(8'h00);
        resp_q.push_back(8'h00);
        resp_q.push_back(8'h01);
        resp_q.push_back(8'hAA);
      end
      CMD_APP:          resp_q.push_back(R1_IDLE);
      ACMD_SEND_OP_COND: begin
        if (busy_left > 0) begin
          busy_left--;
          resp_q.push_back(R1_IDLE);
        end else begin
          resp_q.push_back(R1_READY);
        end
      end
      CMD_READ_SINGLE: begin
        resp_q.push_back(R1_READY);
        resp_q.push_back(FILL_BYTE);
        resp_q.push_back(FILL_BYTE);
        resp_q.push_back(DATA_TOKEN);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          resp_q.push_back(block_byte(f.arg, i));
        end
        // data crc that the reader drops
        resp_q.push_back(8'h3C);
        resp_q.push_back(8'hC3);
      end
      // illegal command
      default: resp_q.push_back(8'h04);
    endcase
  endtask

  task automatic take_byte(byte_t b);
    cmd_frame_t f;
    if (cs) begin
      pre_cnt++;
      fidx = 0;
    end else if (fidx != 0 || b[7:6] == 2'b01) begin
      fbuf[fidx] = b;
      fidx++;
      if (fidx == 6) begin
        fidx = 0;
        f = '{index: fbuf[0][5:0], arg: {fbuf[1], fbuf[2], fbuf[3], fbuf[4]}, crc: fbuf[5]};
        if (frame_log.size() == 0) begin
          pre_first = pre_cnt;
        end
        frame_log.push_back(f);
        respond(f);
      end
    end
  endtask

  // sclk edges are seen from the system clock and miso changes after falling sclk
  always @(posedge CLK) begin
    if (RST) begin
      frame_log.delete();
      resp_q.delete();
      pre_cnt   = 0;
      pre_first = 0;
      fidx      = 0;
      in_bits   = 0;
      out_bits  = 0;
      out_sh    = FILL_BYTE;
      busy_left = busy_replies;
      miso     <= 1'b1;
    end else begin
      if (sclk && !sclk_q) begin
        in_sh = {in_sh[6:0], mosi};
        in_bits++;
        if (in_bits == 8) begin
          in_bits = 0;
          take_byte(in_sh);
        end
      end
      if (!sclk && sclk_q) begin
        out_bits++;
        if (out_bits == 8) begin
          out_bits = 0;
          out_sh   = next_byte();
        end else begin
          out_sh = {out_sh[6:0], 1'b1};
        end
        miso <= out_sh[7];
      end
    end
    sclk_q = sclk;
  end

endmodule

`default_nettype wire

/* tb_sd_reader.sv */
`default_nettype none

module tb_sd_reader import sd_pkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DIVIDER  = 2;
  localparam int RETRIES  = 4;
  localparam int N_UNITS  = 11;
  // one block plus init bytes per unit at 16 half-bits per byte, with a margin of 4
  localparam longint WD_NS = longint'(N_UNITS) * (514 + INIT_BYTES) * 16 * DIVIDER * 10 * 4;

  logic    CLK;
  logic    rst_por;
  logic    rst_again;
  logic    RST;
  logic    rd_stb;
  rd_req_t rd_req;
  logic    ready;
  logic    rd_ack;
  logic    init_err;
  logic    out_stb;
  byte_t   out_data;
  logic    out_busy;
  logic    mosi;
  logic    miso;
  logic    sclk;
  logic    cs;

  int      resp_delay;
  int      busy_replies;
  logic    mute;
  logic    stall_en;
  logic    busy_q;
  int      hold_cnt;
  int      ack_cnt;
  int      errors;
  int      checks;
  int      tests;
  byte_t   got_q[$];

  assign RST = rst_por | rst_again;

  tb_clock_gen #(.period(10), .rst_cycles(5)) u_clk (.CLK(CLK), .RST(rst_por));

  sd_reader #(
    .divider     (DIVIDER),
    .fifo_depth  (16),
    .retry_limit (RETRIES)
  ) u_dut (
    .CLK      (CLK),
    .RST      (RST),
    .rd_stb   (rd_stb),
    .rd_req   (rd_req),
    .ready    (ready),
    .rd_ack   (rd_ack),
    .init_err (init_err),
    .out_stb  (out_stb),
    .out_data (out_data),
    .out_busy (out_busy),
    .mosi     (mosi),
    .miso     (miso),
    .sclk     (sclk),
    .cs       (cs)
  );

  sd_card_model u_card (
    .CLK          (CLK),
    .RST          (RST),
    .cs           (cs),
    .sclk         (sclk),
    .mosi         (mosi),
    .miso         (miso),
    .resp_delay   (resp_delay),
    .busy_replies (busy_replies),
    .mute         (mute)
  );

  // ----------------------------------------------------------------------
  // reference model and compare tasks
  // ----------------------------------------------------------------------

  function automatic byte_t expected_byte(logic [31:0] a, int i);
    logic [7:0] mix;
    mix = a[7:0] + a[15:8] + a[23:16] + a[31:24];
    expected_byte = mix ^ i[7:0] ^ {7'd0, i[8]};
  endfunction

  task automatic check_byte(string what, byte_t got, byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(string what, cmd_frame_t got, cmd_frame_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got cmd%0d arg %08h crc %02h, expected cmd%0d arg %08h crc %02h",
               $time, what, got.index, got.arg, got.crc, exp.index, exp.arg, exp.crc);
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // sel 0 waits for ready and sel 1 for init_err
  task automatic wait_level(int sel, int max_cyc, string what);
    int n;
    n = 0;
    while ((sel == 0 ? ready : init_err) !== 1'b1 && n < max_cyc) begin
      @(posedge CLK);
      n++;
    end
    if (n >= max_cyc) begin
      errors++;
      $display("timed out after %0d cycles waiting for %s", max_cyc, what);
    end
  endtask

  task automatic end_test(string name, int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
  endtask

  // ----------------------------------------------------------------------
  // sink side monitor and back-pressure
  // ----------------------------------------------------------------------

  always @(posedge CLK) begin
    if (out_stb) begin
      got_q.push_back(out_data);
      if (busy_q) begin
        errors++;
        $display("[FAIL] %0d ns: out_stb while out_busy was high", $time);
      end
    end
    if (rd_ack) begin
      ack_cnt++;
    end
    busy_q <= out_busy;
  end

  // busy bursts long enough to fill the FIFO
  always @(posedge CLK) begin
    if (!stall_en) begin
      out_busy <= 1'b0;
      hold_cnt <= 0;
    end else if (hold_cnt == 0) begin
      out_busy <= $urandom_range(0, 1);
      hold_cnt <= $urandom_range(1, 1000);
    end else begin
      hold_cnt <= hold_cnt - 1;
    end
  end

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  task automatic reset_dut();
    @(posedge CLK);
    rst_again <= 1'b1;
    repeat (5) @(posedge CLK);
    rst_again <= 1'b0;
  endtask

  task automatic init_sequence(int n_busy);
    int e;
    int base;
    e = errors;
    wait_level(0, 20000, "ready after init");
    check_flag("init_err", init_err, 1'b0);
    check_flag("preamble long enough", u_card.pre_first >= INIT_BYTES, 1'b1);
    check_count("frames seen", u_card.frame_log.size(), 2 + 2 * (n_busy + 1));
    if (u_card.frame_log.size() >= 2) begin
      check_frame("CMD0", u_card.frame_log[0], '{CMD_GO_IDLE, 32'h0, CRC_CMD0});
      check_frame("CMD8", u_card.frame_log[1], '{CMD_SEND_IF_COND, ARG_IF_COND, CRC_CMD8});
    end
    end_test("init sequence", e);
    e = errors;
    for (int k = 0; k <= n_busy; k++) begin
      base = 2 + 2 * k;
      if (base + 1 < u_card.frame_log.size()) begin
        check_frame("CMD55", u_card.frame_log[base], '{CMD_APP, 32'h0, CRC_NONE});
        check_frame("ACMD41", u_card.frame_log[base + 1], '{ACMD_SEND_OP_COND, ARG_HCS, CRC_NONE});
      end
    end
    end_test($sformatf("acmd41 with %0d busy replies", n_busy), e);
  endtask

  task automatic read_block(logic [31:0] a, logic stall);
    int e;
    int n;
    e = errors;
    wait_level(0, 2000, "ready before read");
    got_q.delete();
    ack_cnt  = 0;
    stall_en <= stall;
    @(posedge CLK);
    rd_stb <= 1'b1;
    rd_req <= '{addr: a};
    @(posedge CLK);
    rd_stb <= 1'b0;
    n = 0;
    while ((got_q.size() < BLOCK_BYTES || ack_cnt == 0) && n < 60000) begin
      @(posedge CLK);
      n++;
    end
    if (n >= 60000) begin
      errors++;
      $display("timed out reading block at %08h", a);
    end
    stall_en <= 1'b0;
    repeat (40) @(posedge CLK);
    check_count("bytes received", got_q.size(), BLOCK_BYTES);
    check_count("rd_ack pulses", ack_cnt, 1);
    check_flag("ready after read", ready, 1'b1);
    check_frame("CMD17", u_card.frame_log[$], '{CMD_READ_SINGLE, a, CRC_NONE});
    for (int i = 0; i < got_q.size() && i < BLOCK_BYTES; i++) begin
      check_byte($sformatf("byte %0d", i), got_q[i], expected_byte(a, i));
    end
    end_test($sformatf("read %08h%s", a, stall ? " with back-pressure" : ""), e);
  endtask

  task automatic silent_card();
    int e;
    int n0;
    e = errors;
    mute = 1'b1;
    reset_dut();
    wait_level(1, 20000, "init_err");
    repeat (200) @(posedge CLK);
    n0 = 0;
    foreach (u_card.frame_log[i]) begin
      if (u_card.frame_log[i].index == CMD_GO_IDLE) begin
        n0++;
      end
    end
    check_flag("init_err", init_err, 1'b1);
    check_flag("ready", ready, 1'b0);
    check_count("CMD0 frames", n0, RETRIES);
    end_test("silent card", e);
  endtask

  initial begin
    void'($urandom(32'he6447418));
    rst_again    = 1'b0;
    rd_stb       = 1'b0;
    rd_req       = '0;
    out_busy     = 1'b0;
    busy_q       = 1'b0;
    stall_en     = 1'b0;
    mute         = 1'b0;
    ack_cnt      = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    resp_delay   = $urandom_range(0, 3);
    busy_replies = $urandom_range(0, 5);
    init_sequence(busy_replies);
    busy_replies = $urandom_range(0, 5);
    reset_dut();
    init_sequence(busy_replies);
    for (int i = 0; i < 4; i++) begin
      read_block($urandom, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      read_block($urandom, 1'b1);
    end
    silent_card();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WD_NS);
    $display("watchdog expired after %0d ns, run stopped", WD_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
sd_pkg.sv
spi_byte_engine.sv
sd_sequencer.sv
byte_fifo.sv
sd_reader.sv
tb_clock_gen.sv
sd_card_model.sv
tb_sd_reader.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the SD reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sd_reader \
  -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> PASS" sim.log; then
  exit 0
else
  exit 1
fi
